//--- flist.f
+incdir+dv
source/CachePkg.sv
source/CacheTable.sv
source/LoadPort.sv
source/StorePort.sv
source/LineTransfer.sv
source/MemSequencer.sv
source/CacheSubsystem.sv
dv/CacheSubsystemTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f flist.f --top-module CacheSubsystemTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Build or simulation stopped early"
[ -f sim.log ] && cat sim.log
grep -qx "Finished with no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- dv/CacheTbChecks.svh
// Reference tag model. Which tag sits at which index, and which tags are dirty
int tagIndex [logic [TagWidth-1:0]];
bit dirtyTags [logic [TagWidth-1:0]];

task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
        reportFailure($sformatf("FAIL %s expected %h got %h", name, expected, actual));
endtask

task automatic checkAddr(input string name, input AccessAddr expected, input AccessAddr actual);
    if (actual.raw !== expected.raw)
        reportFailure($sformatf("FAIL %s expected %h got %h", name, expected.raw, actual.raw));
endtask

task automatic checkLoad(input string name, input AguUop expected, input AguUop actual);
    if (actual !== expected)
        reportFailure($sformatf("FAIL %s expected %h got %h", name, expected, actual));
endtask

task automatic checkStore(input string name, input StUop expected, input StUop actual);
    if (actual !== expected)
        reportFailure($sformatf("FAIL %s expected %h got %h", name, expected, actual));
endtask

task automatic checkMemReq(input string name, input logic expWe,
        input logic [SramWidth-1:0] expSram, input logic [ExtWidth-1:0] expExt,
        input logic actWe, input logic [SramWidth-1:0] actSram,
        input logic [ExtWidth-1:0] actExt);
    if (actWe !== expWe || actSram !== expSram || actExt !== expExt)
        reportFailure($sformatf("FAIL %s expected we=%h sram=%h ext=%h got we=%h sram=%h ext=%h",
            name, expWe, expSram, expExt, actWe, actSram, actExt));
endtask

// A fill at idx replaces any tag the model still holds there
task automatic recordFill(input logic [TagWidth-1:0] tag, input int idx);
    logic [TagWidth-1:0] victims [$];
    foreach (tagIndex[t])
        if (tagIndex[t] == idx || t == tag)
            victims.push_back(t);
    foreach (victims[v]) begin
        if (dirtyTags.exists(victims[v]))
            reportFailure($sformatf("Dirty line %h was replaced without a writeback", victims[v]));
        tagIndex.delete(victims[v]);
    end
    tagIndex[tag] = idx;
endtask

task automatic recordWriteback();
    logic [TagWidth-1:0] tag;
    tag = memExtAddr[ExtWidth-1:WordBits];
    if (!tagIndex.exists(tag) || !dirtyTags.exists(tag))
        reportFailure($sformatf("Writeback names tag %h, which is not mapped and dirty", tag));
    checkMemReq("writeback request", 1'b1, {IdxWidth'(tagIndex[tag]), WordBits'(0)},
        {tag, WordBits'(0)}, memWe, memSramAddr, memExtAddr);
    tagIndex.delete(tag);
    dirtyTags.delete(tag);
endtask

//--- dv/CacheSubsystemTb.sv
`timescale 1ns/100ps

module CacheSubsystemTb import CachePkg::*; ();

    localparam int numEntries = 16;
    localparam int IdxWidth = $clog2(numEntries);
    localparam int SramWidth = IdxWidth + WordBits;
    localparam int ExtWidth = TagWidth + WordBits;
    localparam int StallLimit = 1000;
    localparam int OutLimit = 1000;
    localparam int FlushWatch = 200;
    localparam int RandomRows = 80;

    typedef struct {
        logic isStore;
        logic [31:0] addr;
        logic exception;
        logic brTaken;
        logic [SqnWidth-1:0] sqN;
        logic [SqnWidth-1:0] brSqN;
    } StimRow;

    logic clk;
    logic rst;
    BranchProv branch;
    AguUop ldUopIn;
    AguUop ldUopOut;
    StUop stUopIn;
    StUop stUopOut;
    logic ldStall;
    logic stStall;
    logic memCe;
    logic memWe;
    logic [SramWidth-1:0] memSramAddr;
    logic [ExtWidth-1:0] memExtAddr;

    StimRow rows [$];
    integer seed;
    int fillCount;
    int lastFillIndex;
    logic [TagWidth-1:0] lastFillTag;
    logic lastFillWe;
    logic [SramWidth-1:0] lastFillSram;
    logic [ExtWidth-1:0] lastFillExt;

    CacheSubsystem #(.numEntries(numEntries)) CacheSubsystem_i (.*);

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

`include "CacheTbChecks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Every memory request updates the model, the latest one is kept for the miss check
    always @(negedge clk) begin
        if (!rst && memCe === 1'b1) begin
            lastFillTag = memExtAddr[ExtWidth-1:WordBits];
            lastFillIndex = int'(memSramAddr[SramWidth-1:WordBits]);
            lastFillWe = memWe;
            lastFillSram = memSramAddr;
            lastFillExt = memExtAddr;
            if (memWe) begin
                recordWriteback();
            end else begin
                fillCount++;
                recordFill(lastFillTag, lastFillIndex);
            end
        end
    end

    task automatic addRow(input logic isStore, input logic [31:0] addr, input logic exc,
            input logic brTaken, input logic [SqnWidth-1:0] sqN,
            input logic [SqnWidth-1:0] brSqN);
        StimRow r;
        r.isStore = isStore;
        r.addr = addr;
        r.exception = exc;
        r.brTaken = brTaken;
        r.sqN = sqN;
        r.brSqN = brSqN;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        int pick;
        logic [31:0] addr;
        // IO and exception passthrough
        addRow(1'b0, 32'hffe0_0010, 1'b0, 1'b0, 6'd1, 6'd0);
        addRow(1'b1, 32'hfe00_0104, 1'b0, 1'b0, 6'd2, 6'd0);
        addRow(1'b0, 32'h0000_1234, 1'b1, 1'b0, 6'd3, 6'd0);
        // Miss, then hits on the same line
        addRow(1'b0, 32'h0012_3408, 1'b0, 1'b0, 6'd4, 6'd0);
        addRow(1'b0, 32'h0012_34fc, 1'b0, 1'b0, 6'd5, 6'd0);
        addRow(1'b1, 32'h0012_3480, 1'b0, 1'b0, 6'd6, 6'd0);
        addRow(1'b1, 32'h0045_6710, 1'b0, 1'b0, 6'd7, 6'd0);
        // Younger load dropped, older load kept
        addRow(1'b0, 32'h0099_0000, 1'b0, 1'b1, 6'd10, 6'd5);
        addRow(1'b0, 32'h0099_00c4, 1'b0, 1'b1, 6'd12, 6'd20);
        // Pool of 24 tags against 16 entries
        for (int i = 0; i < RandomRows; i++) begin
            pick = $unsigned($random(seed)) % 24;
            addr = {24'h00a000 + 24'(pick), 8'($random(seed))};
            addRow(1'($random(seed)), addr, 1'b0, 1'b0, 6'(i), 6'd0);
        end
    endtask

    task automatic checkResetState();
        checkFlag("memCe", 1'b0, memCe);
        checkFlag("ldUopOut.valid", 1'b0, ldUopOut.valid);
        checkFlag("stUopOut.valid", 1'b0, stUopOut.valid);
        checkFlag("ldStall", 1'b0, ldStall);
        checkFlag("stStall", 1'b0, stStall);
    endtask

    task automatic applyRow(input StimRow r);
        AguUop ld;
        StUop st;
        AguUop expLd;
        StUop expSt;
        logic [TagWidth-1:0] tag;
        logic signed [SqnWidth-1:0] age;
        logic cached;
        logic flushed;
        logic outValid;
        int waited;
        int lat;
        int limit;
        int fillsBefore;
        int expIndex;

        tag = r.addr[31:32-TagWidth];
        age = r.sqN - r.brSqN;
        flushed = !r.isStore && r.brTaken && !age[SqnWidth-1] && age != '0;
        cached = r.addr[31:24] < IoRegionTop && !(!r.isStore && r.exception);
        ld = '0;
        ld.valid = 1'b1;
        ld.addr.raw = r.addr;
        ld.sqN = r.sqN;
        ld.exception = r.exception;
        st = '0;
        st.valid = 1'b1;
        st.addr.raw = r.addr;
        st.data = $random(seed);
        st.wmask = 4'($random(seed));

        @(posedge clk);
        branch <= '0;
        if (r.isStore)
            stUopIn <= st;
        else
            ldUopIn <= ld;

        // Hold the uop while the port is stalled
        waited = 0;
        @(negedge clk);
        while (r.isStore ? stStall : ldStall) begin
            waited++;
            if (waited > StallLimit)
                reportFailure("Timeout while the port never accepted the uop");
            @(negedge clk);
        end

        @(posedge clk);
        fillsBefore = fillCount;
        ldUopIn.valid <= 1'b0;
        stUopIn.valid <= 1'b0;
        if (r.brTaken)
            branch <= {1'b1, r.brSqN};

        lat = 1;
        limit = flushed ? FlushWatch : OutLimit;
        @(negedge clk);
        checkFlag("memCe after accept", 1'b0, memCe);
        outValid = r.isStore ? stUopOut.valid : ldUopOut.valid;
        while (!outValid && lat < limit) begin
            @(posedge clk);
            branch <= '0;
            @(negedge clk);
            lat++;
            outValid = r.isStore ? stUopOut.valid : ldUopOut.valid;
        end

        if (flushed) begin
            if (outValid)
                reportFailure("A load younger than a taken branch came out");
            checkFlag("ldStall after flush", 1'b0, ldStall);
        end else begin
            if (!outValid)
                reportFailure("Timeout while waiting for the uop to come out");
            expIndex = 0;
            if (!cached) begin
                if (lat != 1)
                    reportFailure("Passthrough access took more than one cycle");
            end else if (lat == 1) begin
                if (fillCount != fillsBefore || !tagIndex.exists(tag))
                    reportFailure("One-cycle hit on a tag that the model has not mapped");
                expIndex = tagIndex[tag];
            end else begin
                // A load may also ride a fill of its line already in flight
                if (lastFillTag !== tag || fillCount > fillsBefore + 1 ||
                        (fillCount == fillsBefore && r.isStore))
                    reportFailure("Miss without exactly one fill request for its tag");
                checkMemReq("fill request", 1'b0, {IdxWidth'(lastFillIndex), WordBits'(0)},
                    {tag, WordBits'(0)}, lastFillWe, lastFillSram, lastFillExt);
                expIndex = lastFillIndex;
            end
            if (r.isStore) begin
                expSt = st;
                if (cached)
                    expSt.addr.fields.line = TagWidth'(expIndex);
                checkAddr("stUopOut.addr", expSt.addr, stUopOut.addr);
                checkStore("stUopOut", expSt, stUopOut);
                if (cached)
                    dirtyTags[tag] = 1'b1;
            end else begin
                expLd = ld;
                if (cached)
                    expLd.addr.fields.line = TagWidth'(expIndex);
                checkAddr("ldUopOut.addr", expLd.addr, ldUopOut.addr);
                checkLoad("ldUopOut", expLd, ldUopOut);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        branch = '0;
        ldUopIn = '0;
        stUopIn = '0;
        seed = 32'he602_89e5;
        fillCount = 0;
        lastFillIndex = 0;
        lastFillTag = '0;
        lastFillWe = 1'b0;
        lastFillSram = '0;
        lastFillExt = '0;
        buildTable();

        // 16 reset edges, then one more check after release
        repeat (15) begin
            @(negedge clk);
            checkResetState();
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkResetState();
        @(negedge clk);
        checkResetState();

        foreach (rows[i])
            applyRow(rows[i]);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- source/CacheSubsystem.sv
`timescale 1ns/100ps

module CacheSubsystem import CachePkg::*; #(
    parameter int numEntries = 16,
    localparam int IdxWidth = $clog2(numEntries)
) (
    input  logic clk,
    input  logic rst,
    input  BranchProv branch,
    input  AguUop ldUopIn,
    output AguUop ldUopOut,
    input  StUop stUopIn,
    output StUop stUopOut,
    output logic ldStall,
    output logic stStall,
    output logic memCe,
    output logic memWe,
    output logic [IdxWidth+WordBits-1:0] memSramAddr,
    output logic [TagWidth+WordBits-1:0] memExtAddr
);

    logic [TagWidth-1:0] ldTag, stTag, ldMissTag, stMissTag, allocTag, fillTag, handTag;
    logic [IdxWidth-1:0] ldIndex, stIndex, ldTouchIndex, stTouchIndex;
    logic [IdxWidth-1:0] allocIndex, fillIndex, handIndex;
    logic ldHit, stHit, ldTouch, stTouch, ldMissValid, stMissValid, ldQuiet, stQuiet;
    logic invalidate, allocate, fillDone, fillDirty, handValid, handUsed, handDirty;
    logic fillActive, xferWait, evicting, memBusy;
    logic [ProgressWidth-1:0] memProgress;

    CacheTable #(.numEntries(numEntries)) cacheTable_i (.*);

    LoadPort #(.numEntries(numEntries)) loadPort_i (
        .clk, .rst, .branch, .uopIn(ldUopIn), .uopOut(ldUopOut), .ldStall,
        .ldTag, .ldHit, .ldIndex, .ldTouch, .ldTouchIndex,
        .ldMissValid, .ldMissTag, .ldQuiet,
        .fillActive, .fillTag, .fillIndex, .xferWait, .memBusy, .memProgress
    );

    StorePort #(.numEntries(numEntries)) storePort_i (
        .clk, .rst, .uopIn(stUopIn), .uopOut(stUopOut), .stStall,
        .stTag, .stHit, .stIndex, .stTouch, .stTouchIndex,
        .stMissValid, .stMissTag, .stQuiet,
        .fillActive, .fillTag, .fillIndex, .xferWait, .evicting, .memBusy
    );

    LineTransfer #(.numEntries(numEntries)) lineTransfer_i (.*);

    MemSequencer memSequencer_i (.clk, .rst, .memCe, .memBusy, .memProgress);

endmodule

//--- source/MemSequencer.sv
`timescale 1ns/100ps

module MemSequencer import CachePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic memCe,
    output logic memBusy,
    output logic [ProgressWidth-1:0] memProgress
);

    // One word per cycle, no data moved
    always_ff @(posedge clk) begin
        if (rst) begin
            memBusy <= 1'b0;
            memProgress <= '0;
        end else if (memCe) begin
            memBusy <= 1'b1;
            memProgress <= '0;
        end else if (memBusy) begin
            memProgress <= memProgress + 1'b1;
            if (memProgress == ProgressWidth'(WordsPerLine - 1))
                memBusy <= 1'b0;
        end
    end

endmodule

//--- source/LineTransfer.sv
`timescale 1ns/100ps

module LineTransfer import CachePkg::*; #(
    parameter int numEntries = 16,
    localparam int IdxWidth = $clog2(numEntries)
) (
    input  logic clk,
    input  logic rst,
    input  BranchProv branch,

    input  logic ldMissValid,
    input  logic [TagWidth-1:0] ldMissTag,
    input  logic stMissValid,
    input  logic [TagWidth-1:0] stMissTag,
    input  logic ldQuiet,
    input  logic stQuiet,

    input  logic [IdxWidth-1:0] handIndex,
    input  logic handValid,
    input  logic handUsed,
    input  logic handDirty,
    input  logic [TagWidth-1:0] handTag,

    output logic invalidate,
    output logic allocate,
    output logic [IdxWidth-1:0] allocIndex,
    output logic [TagWidth-1:0] allocTag,
    output logic fillDone,
    output logic fillDirty,

    output logic fillActive,
    output logic [TagWidth-1:0] fillTag,
    output logic [IdxWidth-1:0] fillIndex,
    output logic xferWait,
    output logic evicting,

    output logic memCe,
    output logic memWe,
    output logic [IdxWidth+WordBits-1:0] memSramAddr,
    output logic [TagWidth+WordBits-1:0] memExtAddr,
    input  logic memBusy
);

    logic freeAvail;
    logic [IdxWidth-1:0] freeIndex;
    logic searching;

    assign searching = !freeAvail && !evicting && !fillActive && !memBusy;
    assign invalidate = searching && handValid && !handUsed && ldQuiet && stQuiet;

    // Loads are served before stores
    assign allocate = freeAvail && !fillActive && !evicting && !branch.taken && !memBusy &&
        (ldMissValid || stMissValid);
    assign allocIndex = freeIndex;
    assign allocTag = ldMissValid ? ldMissTag : stMissTag;

    assign fillDone = fillActive && !xferWait && !memBusy;
    assign fillDirty = stMissValid && stMissTag == fillTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            freeAvail <= 1'b1;
            freeIndex <= '0;
            fillActive <= 1'b0;
            xferWait <= 1'b0;
            evicting <= 1'b0;
            memCe <= 1'b0;
            memWe <= 1'b0;
        end else begin
            memCe <= 1'b0;
            xferWait <= 1'b0;

            // Slot becomes free once the writeback has drained
            if (evicting) begin
                if (!xferWait && !memBusy) begin
                    evicting <= 1'b0;
                    freeAvail <= 1'b1;
                end
            end else if (searching && !handValid) begin
                freeAvail <= 1'b1;
                freeIndex <= handIndex;
            end else if (invalidate) begin
                freeIndex <= handIndex;
                if (handDirty) begin
                    memCe <= 1'b1;
                    memWe <= 1'b1;
                    memSramAddr <= {handIndex, WordBits'(0)};
                    memExtAddr <= {handTag, WordBits'(0)};
                    evicting <= 1'b1;
                    xferWait <= 1'b1;
                end else begin
                    freeAvail <= 1'b1;
                end
            end

            if (fillDone) begin
                fillActive <= 1'b0;
            end else if (allocate) begin
                memCe <= 1'b1;
                memWe <= 1'b0;
                memSramAddr <= {freeIndex, WordBits'(0)};
                memExtAddr <= {allocTag, WordBits'(0)};
                fillActive <= 1'b1;
                fillTag <= allocTag;
                fillIndex <= freeIndex;
                xferWait <= 1'b1;
                freeAvail <= 1'b0;
            end
        end
    end

endmodule

//--- source/StorePort.sv
`timescale 1ns/100ps

module StorePort import CachePkg::*; #(
    parameter int numEntries = 16,
    localparam int IdxWidth = $clog2(numEntries)
) (
    input  logic clk,
    input  logic rst,

    input  StUop uopIn,
    output StUop uopOut,
    output logic stStall,

    output logic [TagWidth-1:0] stTag,
    input  logic stHit,
    input  logic [IdxWidth-1:0] stIndex,
    output logic stTouch,
    output logic [IdxWidth-1:0] stTouchIndex,

    output logic stMissValid,
    output logic [TagWidth-1:0] stMissTag,
    output logic stQuiet,

    input  logic fillActive,
    input  logic [TagWidth-1:0] fillTag,
    input  logic [IdxWidth-1:0] fillIndex,
    input  logic xferWait,
    input  logic evicting,
    input  logic memBusy
);

    StUop parkUop;
    logic accept;
    logic inBypass;
    logic parkHit;
    logic parkFill;

    // No store hits while a line is moving
    assign stStall = parkUop.valid || fillActive || evicting;
    assign accept = uopIn.valid && !stStall;
    assign inBypass = isIoAddr(uopIn.addr);

    assign stTag = parkUop.valid ? parkUop.addr.fields.line : uopIn.addr.fields.line;
    assign parkHit = parkUop.valid && stHit;
    assign parkFill = parkUop.valid && fillActive && !xferWait && !memBusy &&
        fillTag == parkUop.addr.fields.line;

    assign stTouch = (accept && !inBypass && stHit) || parkHit;
    assign stTouchIndex = stIndex;

    assign stMissValid = parkUop.valid && !stHit;
    assign stMissTag = parkUop.addr.fields.line;
    assign stQuiet = !accept && !parkHit && !uopOut.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            parkUop.valid <= 1'b0;
            uopOut.valid <= 1'b0;
        end else begin
            uopOut.valid <= 1'b0;
            if (parkHit || parkFill) begin
                uopOut <= parkUop;
                uopOut.addr <= lineRewrite(parkUop.addr,
                    TagWidth'(parkHit ? stIndex : fillIndex));
                parkUop.valid <= 1'b0;
            end
            if (accept) begin
                if (inBypass) begin
                    uopOut <= uopIn;
                end else if (stHit) begin
                    uopOut <= uopIn;
                    uopOut.addr <= lineRewrite(uopIn.addr, TagWidth'(stIndex));
                end else begin
                    parkUop <= uopIn;
                end
            end
        end
    end

endmodule

//--- source/LoadPort.sv
`timescale 1ns/100ps

module LoadPort import CachePkg::*; #(
    parameter int numEntries = 16,
    localparam int IdxWidth = $clog2(numEntries)
) (
    input  logic clk,
    input  logic rst,
    input  BranchProv branch,

    input  AguUop uopIn,
    output AguUop uopOut,
    output logic ldStall,

    output logic [TagWidth-1:0] ldTag,
    input  logic ldHit,
    input  logic [IdxWidth-1:0] ldIndex,
    output logic ldTouch,
    output logic [IdxWidth-1:0] ldTouchIndex,

    output logic ldMissValid,
    output logic [TagWidth-1:0] ldMissTag,
    output logic ldQuiet,

    input  logic fillActive,
    input  logic [TagWidth-1:0] fillTag,
    input  logic [IdxWidth-1:0] fillIndex,
    input  logic xferWait,
    input  logic memBusy,
    input  logic [ProgressWidth-1:0] memProgress
);

    AguUop parkUop;
    logic signed [SqnWidth-1:0] inAge;
    logic signed [SqnWidth-1:0] parkAge;
    logic inFlush;
    logic parkFlush;
    logic accept;
    logic inBypass;
    logic parkHit;
    logic parkFill;

    assign inAge = $signed(uopIn.sqN - branch.sqN);
    assign parkAge = $signed(parkUop.sqN - branch.sqN);
    assign inFlush = branch.taken && inAge > 0;
    assign parkFlush = parkUop.valid && branch.taken && parkAge > 0;

    assign ldStall = parkUop.valid;
    assign accept = uopIn.valid && !parkUop.valid && !inFlush;
    assign inBypass = uopIn.exception || isIoAddr(uopIn.addr);

    // Parked uop reuses the lookup while the port is stalled
    assign ldTag = parkUop.valid ? parkUop.addr.fields.line : uopIn.addr.fields.line;
    assign parkHit = parkUop.valid && ldHit;

    // Early release once the fill has passed the parked word
    assign parkFill = parkUop.valid && fillActive && !xferWait &&
        fillTag == parkUop.addr.fields.line &&
        (!memBusy || memProgress > {1'b0, parkUop.addr.fields.word});

    assign ldTouch = (accept && !inBypass && ldHit) || (parkHit && !parkFlush);
    assign ldTouchIndex = ldIndex;

    assign ldMissValid = parkUop.valid && !ldHit;
    assign ldMissTag = parkUop.addr.fields.line;
    assign ldQuiet = !accept && !parkHit && !uopOut.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            parkUop.valid <= 1'b0;
            uopOut.valid <= 1'b0;
        end else begin
            uopOut.valid <= 1'b0;
            if (parkFlush) begin
                parkUop.valid <= 1'b0;
            end else if (parkHit || parkFill) begin
                uopOut <= parkUop;
                uopOut.addr <= lineRewrite(parkUop.addr,
                    TagWidth'(parkHit ? ldIndex : fillIndex));
                parkUop.valid <= 1'b0;
            end
            if (accept) begin
                if (inBypass) begin
                    uopOut <= uopIn;
                end else if (ldHit) begin
                    uopOut <= uopIn;
                    uopOut.addr <= lineRewrite(uopIn.addr, TagWidth'(ldIndex));
                end else begin
                    parkUop <= uopIn;
                end
            end
        end
    end

endmodule

//--- source/CacheTable.sv
`timescale 1ns/100ps

module CacheTable import CachePkg::*; #(
    parameter int numEntries = 16,
    localparam int IdxWidth = $clog2(numEntries)
) (
    input  logic clk,
    input  logic rst,

    input  logic [TagWidth-1:0] ldTag,
    input  logic [TagWidth-1:0] stTag,
    output logic ldHit,
    output logic stHit,
    output logic [IdxWidth-1:0] ldIndex,
    output logic [IdxWidth-1:0] stIndex,

    input  logic ldTouch,
    input  logic [IdxWidth-1:0] ldTouchIndex,
    input  logic stTouch,
    input  logic [IdxWidth-1:0] stTouchIndex,

    input  logic invalidate,
    input  logic allocate,
    input  logic fillDone,
    input  logic fillDirty,
    input  logic [IdxWidth-1:0] allocIndex,
    input  logic [TagWidth-1:0] allocTag,

    output logic [IdxWidth-1:0] handIndex,
    output logic handValid,
    output logic handUsed,
    output logic handDirty,
    output logic [TagWidth-1:0] handTag
);

    logic [TagWidth-1:0] tagMem [numEntries];
    logic [numEntries-1:0] validBits;
    logic [numEntries-1:0] usedBits;
    logic [numEntries-1:0] dirtyBits;
    logic [IdxWidth-1:0] hand;

    // Fully associative search, one per port
    always_comb begin
        ldHit = 1'b0;
        ldIndex = '0;
        stHit = 1'b0;
        stIndex = '0;
        for (int i = 0; i < numEntries; i++) begin
            if (validBits[i] && tagMem[i] == ldTag) begin
                ldHit = 1'b1;
                ldIndex = IdxWidth'(i);
            end
            if (validBits[i] && tagMem[i] == stTag) begin
                stHit = 1'b1;
                stIndex = IdxWidth'(i);
            end
        end
    end

    assign handIndex = hand;
    assign handValid = validBits[hand];
    assign handUsed = usedBits[hand];
    assign handDirty = dirtyBits[hand];
    assign handTag = tagMem[hand];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            usedBits <= '0;
            dirtyBits <= '0;
            hand <= '0;
        end else begin
            // Second chance: skip used entries, taking their used bit away
            if (handValid && handUsed) begin
                usedBits[hand] <= 1'b0;
                hand <= (hand == IdxWidth'(numEntries - 1)) ? '0 : hand + 1'b1;
            end
            if (ldTouch)
                usedBits[ldTouchIndex] <= 1'b1;
            if (stTouch) begin
                usedBits[stTouchIndex] <= 1'b1;
                dirtyBits[stTouchIndex] <= 1'b1;
            end
            if (invalidate) begin
                validBits[hand] <= 1'b0;
                usedBits[hand] <= 1'b0;
            end
            if (allocate)
                usedBits[allocIndex] <= 1'b1;
            // Fill last so it wins over a touch
            if (fillDone) begin
                validBits[allocIndex] <= 1'b1;
                usedBits[allocIndex] <= 1'b1;
                dirtyBits[allocIndex] <= fillDirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocate)
            tagMem[allocIndex] <= allocTag;
    end

endmodule

//--- source/CachePkg.sv
package CachePkg;

    localparam int SqnWidth = 6;
    localparam logic [7:0] IoRegionTop = 8'hfe;

    // Line geometry
    localparam int WordsPerLine = 64;
    localparam int WordBits = $clog2(WordsPerLine);
    localparam int TagWidth = 32 - WordBits - 2;
    localparam int ProgressWidth = WordBits + 1;

    typedef struct packed {
        logic taken;
        logic [SqnWidth-1:0] sqN;
    } BranchProv;

    typedef struct packed {
        logic [TagWidth-1:0] line;
        logic [WordBits-1:0] word;
        logic [1:0] byteSel;
    } LineAddr;

    // Line field is the tag on input, the entry index once rewritten
    typedef union packed {
        logic [31:0] raw;
        LineAddr fields;
    } AccessAddr;

    typedef struct packed {
        logic valid;
        AccessAddr addr;
        logic [SqnWidth-1:0] sqN;
        logic exception;
    } AguUop;

    typedef struct packed {
        logic valid;
        AccessAddr addr;
        logic [31:0] data;
        logic [3:0] wmask;
    } StUop;

    function automatic logic isIoAddr(AccessAddr a);
        return a.raw[31:24] >= IoRegionTop;
    endfunction

    function automatic AccessAddr lineRewrite(AccessAddr a, logic [TagWidth-1:0] line);
        AccessAddr r;
        r = a;
        r.fields.line = line;
        return r;
    endfunction

endpackage
